/* filelist.f */
rvPkg.sv
instMem.sv
regFile.sv
dataMem.sv
mainControl.sv
execUnit.sv
singleCpu.sv
tb_singleCpu_assert.sv
tb_singleCpu.sv

/* run.sh */
#!/bin/sh
# Build and run the single-cycle CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_singleCpu -f filelist.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "STATUS: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

/* tb_singleCpu.sv */
`default_nettype none

module tb_singleCpu;
    import rvPkg::*;

    logic   CLK;
    logic   arstN;
    imemWrT imemLoad;
    retireT trace;

    logic [31:0] prog [$];
    regWrT       expReg [$];
    memWrT       expMem [$];
    logic [31:0] model [32];                // Architectural register state
    logic [31:0] dataModel [logic [31:0]];  // Stored words by byte address
    logic [31:0] lcgState;

    singleCpu dut_i (
        .CLK      (CLK),
        .arstN    (arstN),
        .imemLoad (imemLoad),
        .trace    (trace)
    );

    always #20 CLK = ~CLK;

    function logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // RV32I result for a funct3 and the sub bit
    function logic [31:0] refAlu(input logic [2:0] f3, input logic isSub,
                                 input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Instruction encoders per format
    function logic [31:0] rWord(input logic [2:0] f3, input logic isSub,
                                input logic [4:0] rd, input logic [4:0] rs1,
                                input logic [4:0] rs2);
        return {1'b0, isSub, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function logic [31:0] iWord(input logic [2:0] f3, input logic [4:0] rd,
                                input logic [4:0] rs1, input logic [11:0] imm,
                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function logic [31:0] sWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function logic [31:0] bWord(input logic isNe, input logic [4:0] rs1,
                                input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 2'b00, isNe, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function logic [31:0] uWord(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function logic [31:0] jWord(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function regWrT mkRegWr(input logic [4:0] rd, input logic [31:0] data);
        return '{en: (rd != 5'd0), rd: rd, data: data};
    endfunction

    task abortRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task checkRegWr(input string name, input regWrT exp, input regWrT act);
        if ((act.en !== exp.en) || (exp.en && ((act.rd !== exp.rd) || (act.data !== exp.data))))
            abortRun($sformatf("Error: %s: expected regWr %h, actual %h", name, exp, act));
    endtask

    task checkMemWr(input string name, input memWrT exp, input memWrT act);
        if ((act.en !== exp.en) ||
            (exp.en && ((act.addr !== exp.addr) || (act.data !== exp.data))))
            abortRun($sformatf("Error: %s: expected memWr %h, actual %h", name, exp, act));
    endtask

    task checkPc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            abortRun($sformatf("Error: %s: expected pc %h, actual %h", name, exp, act));
    endtask

    task checkInstr(input string name, input instWordU exp, input instWordU act);
        if (act !== exp)
            abortRun($sformatf("Error: %s: expected instr %h, actual %h", name, exp, act));
    endtask

    task clearModels();
        prog.delete();
        expReg.delete();
        expMem.delete();
        dataModel.delete();
        for (int k = 0; k < 32; k++) begin
            model[k] = '0;
        end
    endtask

    task pushExp(input logic [4:0] rd, input logic [31:0] val, input memWrT m);
        expReg.push_back(mkRegWr(rd, val));
        expMem.push_back(m);
        if (rd != 5'd0) model[rd] = val;  // x0 stays zero
    endtask

    task immOp(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
               input logic [11:0] imm);
        prog.push_back(iWord(f3, rd, rs1, imm, OP_IMM));
        pushExp(rd, refAlu(f3, 1'b0, model[rs1], sext12(imm)), '0);
    endtask

    task regOp(input logic [2:0] f3, input logic isSub, input logic [4:0] rd,
               input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back(rWord(f3, isSub, rd, rs1, rs2));
        pushExp(rd, refAlu(f3, isSub, model[rs1], model[rs2]), '0);
    endtask

    task luiOp(input logic [4:0] rd, input logic [19:0] imm);
        prog.push_back(uWord(rd, imm));
        pushExp(rd, {imm, 12'h000}, '0);
    endtask

    task storeWord(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] byteAddr;
        byteAddr = model[rs1] + sext12(imm);
        dataModel[byteAddr] = model[rs2];
        prog.push_back(sWord(rs2, rs1, imm));
        pushExp(5'd0, 32'd0, '{en: 1'b1, addr: byteAddr, data: model[rs2]});
    endtask

    task loadWord(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] byteAddr;
        byteAddr = model[rs1] + sext12(imm);
        prog.push_back(iWord(3'b010, rd, rs1, imm, OP_LOAD));
        pushExp(rd, dataModel[byteAddr], '0);
    endtask

    // lui plus addi with the upper part rounded for the signed low half
    task loadConst(input logic [4:0] rd, input logic [31:0] val);
        logic [19:0] hi;
        hi = val[31:12] + {19'b0, val[11]};
        luiOp(rd, hi);
        immOp(3'b000, rd, rd, val[11:0]);
    endtask

    // Program load under reset ending in a jal-to-self halt
    task loadProgram();
        int n;
        int k;
        prog.push_back(jWord(5'd0, 21'd0));
        n = prog.size();
        @(posedge CLK);
        #1;
        arstN = 1'b0;
        for (k = 0; k < ((n > 16) ? n : 16); k++) begin
            imemLoad = '{en: (k < n), addr: 8'(k), data: (k < n) ? prog[k] : 32'h0};
            @(posedge CLK);
            #1;
        end
        imemLoad = '0;
        arstN    = 1'b1;
    endtask

    task waitPc(input string name, input logic [31:0] pcExp);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && (cycles < 64)) begin
            @(negedge CLK);  // Trace settled mid-cycle
            cycles++;
            found = (trace.pc === pcExp);
        end
        if (!found) abortRun($sformatf("Timeout in %s: pc %h never reached", name, pcExp));
    endtask

    // One instruction retires per edge
    task nextRetire(input string name, input logic [31:0] pcExp);
        @(negedge CLK);
        checkPc(name, pcExp, trace.pc);
    endtask

    task runSequential(input string name);
        int i;
        loadProgram();
        for (i = 0; i < expReg.size(); i++) begin
            waitPc(name, 4 * i);
            checkInstr(name, prog[i], trace.instr);
            checkRegWr(name, expReg[i], trace.regWr);
            checkMemWr(name, expMem[i], trace.memWr);
        end
    endtask

    task aluOpsTest();
        clearModels();
        immOp(3'b000, 5'd1, 5'd0, 12'h4D2);
        immOp(3'b000, 5'd2, 5'd0, -12'sd77);
        immOp(3'b111, 5'd3, 5'd1, 12'h0F0);
        immOp(3'b110, 5'd4, 5'd2, 12'h123);
        immOp(3'b100, 5'd5, 5'd1, 12'hFFF);  // Bitwise not
        immOp(3'b010, 5'd6, 5'd2, 12'd5);
        immOp(3'b010, 5'd7, 5'd1, 12'd5);
        regOp(3'b000, 1'b0, 5'd8, 5'd1, 5'd2);
        regOp(3'b000, 1'b1, 5'd9, 5'd1, 5'd2);
        regOp(3'b111, 1'b0, 5'd10, 5'd1, 5'd2);
        regOp(3'b110, 1'b0, 5'd11, 5'd1, 5'd2);
        regOp(3'b100, 1'b0, 5'd12, 5'd1, 5'd2);
        regOp(3'b010, 1'b0, 5'd13, 5'd2, 5'd1);
        regOp(3'b010, 1'b0, 5'd14, 5'd1, 5'd2);
        immOp(3'b000, 5'd16, 5'd0, 12'd35);  // Shift amount wraps to 3
        regOp(3'b001, 1'b0, 5'd17, 5'd1, 5'd16);
        regOp(3'b101, 1'b0, 5'd18, 5'd2, 5'd16);
        runSequential("aluOps");
    endtask

    task loadStoreTest();
        clearModels();
        immOp(3'b000, 5'd1, 5'd0, 12'h040);  // Base address
        immOp(3'b000, 5'd2, 5'd0, -12'sd123);
        immOp(3'b000, 5'd3, 5'd0, 12'h7FF);
        storeWord(5'd2, 5'd1, 12'd8);
        storeWord(5'd3, 5'd1, -12'sd4);
        immOp(3'b000, 5'd2, 5'd0, 12'd0);    // Load must restore it
        loadWord(5'd4, 5'd1, 12'd8);
        loadWord(5'd5, 5'd1, -12'sd4);
        regOp(3'b000, 1'b0, 5'd6, 5'd4, 5'd5);
        runSequential("loadStore");
    endtask

    task branchTest();
        logic [31:0] expPcs [$];
        int          k;
        clearModels();
        prog.push_back(iWord(3'b000, 5'd1, 5'd0, 12'd5, OP_IMM));
        prog.push_back(iWord(3'b000, 5'd2, 5'd0, 12'd5, OP_IMM));
        prog.push_back(bWord(1'b0, 5'd1, 5'd2, 13'd8));     // beq taken to 16
        prog.push_back(iWord(3'b000, 5'd3, 5'd0, 12'd1, OP_IMM));
        prog.push_back(bWord(1'b1, 5'd1, 5'd2, 13'd8));     // bne falls through
        prog.push_back(iWord(3'b000, 5'd2, 5'd0, 12'd7, OP_IMM));
        prog.push_back(bWord(1'b1, 5'd1, 5'd2, 13'd12));    // bne taken to 36
        prog.push_back(iWord(3'b000, 5'd3, 5'd0, 12'd2, OP_IMM));
        prog.push_back(iWord(3'b000, 5'd3, 5'd0, 12'd3, OP_IMM));
        prog.push_back(bWord(1'b0, 5'd1, 5'd2, -13'sd36));  // beq backward, not taken
        expPcs = '{32'd4, 32'd8, 32'd16, 32'd20, 32'd24, 32'd36, 32'd40, 32'd40};
        loadProgram();
        waitPc("branch", 32'd0);
        for (k = 0; k < expPcs.size(); k++) begin
            nextRetire("branch", expPcs[k]);
        end
    endtask

    task luiJalTest();
        clearModels();
        prog.push_back(uWord(5'd5, 20'hABCDE));
        prog.push_back(jWord(5'd1, 21'd12));   // To 16 with link 8
        prog.push_back(iWord(3'b000, 5'd9, 5'd0, 12'd1, OP_IMM));
        prog.push_back(iWord(3'b000, 5'd9, 5'd0, 12'd2, OP_IMM));
        prog.push_back(iWord(3'b000, 5'd6, 5'd5, 12'h123, OP_IMM));
        prog.push_back(jWord(5'd0, -21'sd20));  // Back to 0 without link
        loadProgram();
        waitPc("luiJal", 32'd0);
        checkRegWr("luiJal", mkRegWr(5'd5, 32'hABCD_E000), trace.regWr);
        nextRetire("luiJal", 32'd4);
        checkRegWr("luiJal", mkRegWr(5'd1, 32'd8), trace.regWr);
        nextRetire("luiJal", 32'd16);
        checkRegWr("luiJal", mkRegWr(5'd6, 32'hABCD_E123), trace.regWr);
        nextRetire("luiJal", 32'd20);
        checkRegWr("luiJal", mkRegWr(5'd0, 32'd0), trace.regWr);
        nextRetire("luiJal", 32'd0);
    endtask

    task zeroRegTest();
        clearModels();
        immOp(3'b000, 5'd0, 5'd0, 12'd55);
        immOp(3'b000, 5'd1, 5'd0, 12'd99);
        regOp(3'b000, 1'b0, 5'd2, 5'd0, 5'd1);
        regOp(3'b000, 1'b0, 5'd0, 5'd1, 5'd1);
        regOp(3'b000, 1'b0, 5'd3, 5'd0, 5'd0);
        runSequential("zeroReg");
    endtask

    task randomAluTest();
        logic [23:0] f3Tab;
        logic [31:0] sel;
        logic [2:0]  pick;
        clearModels();
        // add, sub, and, or, xor, slt, sll, srl from index 0 up
        f3Tab = {3'b101, 3'b001, 3'b010, 3'b100, 3'b110, 3'b111, 3'b000, 3'b000};
        repeat (20) begin
            loadConst(5'd1, lcgNext());
            loadConst(5'd2, lcgNext());
            sel  = lcgNext();
            pick = sel[31:29];
            regOp(f3Tab[pick * 3 +: 3], (pick == 3'd1), 5'd3, 5'd1, 5'd2);
        end
        runSequential("randomAlu");
    endtask

    initial begin
        CLK      = 1'b0;
        arstN    = 1'b0;
        imemLoad = '0;
        lcgState = 32'h8873_c405;
        aluOpsTest();
        loadStoreTest();
        branchTest();
        luiJalTest();
        zeroRegTest();
        randomAluTest();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_singleCpu_assert.sv */
`default_nettype none

module singleCpuAssert (
    input logic          CLK,
    input logic          arstN,
    input rvPkg::retireT trace
);

    // Fetch stays word aligned
    pcAligned: assert property (@(posedge CLK) disable iff (!arstN)
        trace.pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    noWriteX0: assert property (@(posedge CLK) disable iff (!arstN)
        trace.regWr.en |-> (trace.regWr.rd != 5'd0))
        else $error("register write to x0");

    // No instruction writes both a register and memory
    oneWriteOnly: assert property (@(posedge CLK) disable iff (!arstN)
        !(trace.regWr.en && trace.memWr.en))
        else $error("register and memory write together");

    pcKnown: assert property (@(posedge CLK) disable iff (!arstN)
        !$isunknown(trace.pc))
        else $error("pc unknown after reset");

endmodule

bind singleCpu singleCpuAssert singleCpuAssert_i (
    .CLK   (CLK),
    .arstN (arstN),
    .trace (trace)
);

`default_nettype wire

/* singleCpu.sv */
`default_nettype none

module singleCpu (
    input  logic          CLK,
    input  logic          arstN,
    input  rvPkg::imemWrT imemLoad,
    output rvPkg::retireT trace
);
    import rvPkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] pcPlus4;
    logic [XLEN-1:0] pcTarget;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] rs1Val;
    logic [XLEN-1:0] rs2Val;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] wbData;
    logic            taken;
    instWordU        instr;
    ctrlT            ctrl;
    regWrT           regWr;
    memWrT           memWr;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;  // One instruction per edge
        end
    end

    assign pcNext = taken ? pcTarget : pcPlus4;

    instMem instMem_i (
        .CLK   (CLK),
        .load  (imemLoad),
        .addr  (pc[IMEM_AW+1:2]),
        .instr (instr)
    );

    mainControl mainControl_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    regFile regFile_i (
        .CLK   (CLK),
        .arstN (arstN),
        .rs1   (instr.r.rs1),
        .rs2   (instr.r.rs2),
        .rd1   (rs1Val),
        .rd2   (rs2Val),
        .wr    (regWr)
    );

    execUnit execUnit_i (
        .instr     (instr),
        .ctrl      (ctrl),
        .pc        (pc),
        .rs1Val    (rs1Val),
        .rs2Val    (rs2Val),
        .aluResult (aluResult),
        .pcPlus4   (pcPlus4),
        .pcTarget  (pcTarget),
        .taken     (taken)
    );

    dataMem dataMem_i (
        .CLK    (CLK),
        .addr   (aluResult),
        .wrEn   (memWr.en),
        .wrData (rs2Val),
        .rdData (loadData)
    );

    // Write-back select, jal links pc + 4
    assign wbData = ctrl.memToReg ? loadData : (ctrl.jump ? pcPlus4 : aluResult);

    // No state change while held in reset
    assign regWr = '{en: ctrl.regWrite & arstN, rd: instr.r.rd, data: wbData};
    assign memWr = '{en: ctrl.memWrite & arstN, addr: aluResult, data: rs2Val};

    assign trace = '{pc: pc, instr: instr, regWr: regWr, memWr: memWr};

endmodule

`default_nettype wire

/* execUnit.sv */
`default_nettype none

module execUnit (
    input  rvPkg::instWordU        instr,
    input  rvPkg::ctrlT            ctrl,
    input  logic [rvPkg::XLEN-1:0] pc,
    input  logic [rvPkg::XLEN-1:0] rs1Val,
    input  logic [rvPkg::XLEN-1:0] rs2Val,
    output logic [rvPkg::XLEN-1:0] aluResult,
    output logic [rvPkg::XLEN-1:0] pcPlus4,
    output logic [rvPkg::XLEN-1:0] pcTarget,
    output logic                   taken
);
    import rvPkg::*;

    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] opB;
    logic            zero;

    // Sign-extended immediate per format
    always_comb begin
        case (ctrl.immSel)
            IMM_I: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            IMM_S: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            IMM_B: begin
                imm = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            end
            IMM_U: imm = {instr.u.imm, 12'b0};
            IMM_J: begin
                imm = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19to12,
                       instr.j.imm11, instr.j.imm10to1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

    assign opB = ctrl.aluSrcImm ? imm : rs2Val;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:   aluResult = rs1Val + opB;
            ALU_SUB:   aluResult = rs1Val - opB;
            ALU_AND:   aluResult = rs1Val & opB;
            ALU_OR:    aluResult = rs1Val | opB;
            ALU_XOR:   aluResult = rs1Val ^ opB;
            ALU_SLT:   aluResult = {31'b0, $signed(rs1Val) < $signed(opB)};
            ALU_SLL:   aluResult = rs1Val << opB[4:0];
            ALU_SRL:   aluResult = rs1Val >> opB[4:0];  // Logical shift
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // Branch compares via subtract, jal always taken
    assign taken = ctrl.jump | (ctrl.branch & (zero ^ ctrl.branchNe));

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;  // B or J immediate here

endmodule

`default_nettype wire

/* mainControl.sv */
`default_nettype none

module mainControl (
    input  rvPkg::instWordU instr,
    output rvPkg::ctrlT     ctrl
);
    import rvPkg::*;

    logic [2:0] funct3;
    logic       funct7b5;
    aluOpE      aluFunct;

    assign funct3   = instr.r.funct3;
    assign funct7b5 = instr.r.funct7[5];

    // ALU op from funct3, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b000: begin
                // sub only in the register form
                if ((instr.r.opcode == OP_REG) && funct7b5) begin
                    aluFunct = ALU_SUB;
                end else begin
                    aluFunct = ALU_ADD;
                end
            end
            3'b001:  aluFunct = ALU_SLL;
            3'b010:  aluFunct = ALU_SLT;
            3'b100:  aluFunct = ALU_XOR;
            3'b101:  aluFunct = ALU_SRL;
            3'b110:  aluFunct = ALU_OR;
            3'b111:  aluFunct = ALU_AND;
            default: aluFunct = ALU_ADD;  // sltu not supported
        endcase
    end

    always_comb begin
        ctrl        = '0;  // Unknown opcode acts as nop
        ctrl.immSel = IMM_I;
        ctrl.aluOp  = ALU_ADD;
        case (instr.r.opcode)
            OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFunct;
            end
            OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluFunct;
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            OP_STORE: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = IMM_S;
            end
            OP_BRANCH: begin
                ctrl.branch   = (funct3[2:1] == 2'b00);  // beq and bne only
                ctrl.branchNe = funct3[0];
                ctrl.immSel   = IMM_B;
                ctrl.aluOp    = ALU_SUB;
            end
            OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = IMM_U;
                ctrl.aluOp     = ALU_PASSB;
            end
            OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.immSel   = IMM_J;
            end
            default: ;
        endcase
        if (instr.r.rd == 5'd0) begin
            ctrl.regWrite = 1'b0;  // Writes to x0 dropped
        end
    end

endmodule

`default_nettype wire

/* dataMem.sv */
`default_nettype none

module dataMem (
    input  logic                   CLK,
    input  logic [rvPkg::XLEN-1:0] addr,  // Byte address
    input  logic                   wrEn,
    input  logic [rvPkg::XLEN-1:0] wrData,
    output logic [rvPkg::XLEN-1:0] rdData
);
    import rvPkg::*;

    logic [XLEN-1:0]    mem [2**DMEM_AW];
    logic [DMEM_AW-1:0] wordIdx;

    // Byte offset dropped, upper bits wrap
    assign wordIdx = addr[DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;  // Full word only
        end
    end

    assign rdData = mem[wordIdx];

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile (
    input  logic                   CLK,
    input  logic                   arstN,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    output logic [rvPkg::XLEN-1:0] rd1,
    output logic [rvPkg::XLEN-1:0] rd2,
    input  rvPkg::regWrT           wr
);
    import rvPkg::*;

    logic [XLEN-1:0] regs [32];

    // x0 is cleared here and never written afterwards
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.en && (wr.rd != 5'd0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Two read ports, no bypass
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

/* instMem.sv */
`default_nettype none

module instMem (
    input  logic                      CLK,
    input  rvPkg::imemWrT             load,
    input  logic [rvPkg::IMEM_AW-1:0] addr,  // Word address
    output rvPkg::instWordU           instr
);
    import rvPkg::*;

    logic [XLEN-1:0] rom [2**IMEM_AW];

    // Unloaded words read as zero, decoded as a nop
    initial begin
        for (int k = 0; k < 2**IMEM_AW; k++) begin
            rom[k] = '0;
        end
    end

    // Program load port, independent of CPU reset
    always_ff @(posedge CLK) begin
        if (load.en) begin
            rom[load.addr] <= load.data;
        end
    end

    assign instr = rom[addr];  // Combinational fetch

endmodule

`default_nettype wire

/* rvPkg.sv */
`default_nettype none

package rvPkg;

    localparam int XLEN    = 32;
    localparam int IMEM_AW = 8;  // 256 instruction words
    localparam int DMEM_AW = 8;  // 256 data words

    // RV32I major opcodes in use
    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASSB  // Operand B straight through, for lui
    } aluOpE;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } immSelE;

    // Field split per format, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;  // Upper 20 bits of the value
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // One instruction word, every format view
    typedef union packed {
        rTypeT r;
        iTypeT i;
        sTypeT s;
        bTypeT b;
        uTypeT u;
        jTypeT j;
    } instWordU;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        logic   branch;
        logic   branchNe;  // bne instead of beq
        logic   jump;
        immSelE immSel;
        aluOpE  aluOp;
    } ctrlT;

    typedef struct packed {
        logic            en;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } regWrT;

    typedef struct packed {
        logic            en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } memWrT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        instWordU        instr;
        regWrT           regWr;
        memWrT           memWr;
    } retireT;

    typedef struct packed {
        logic               en;
        logic [IMEM_AW-1:0] addr;
        logic [XLEN-1:0]    data;
    } imemWrT;

endpackage

`default_nettype wire
